// File: Bender.yml
package:
  name: rv64_alu

sources:
  - rv_isa_pkg.sv
  - alu_pkg.sv
  - alu_decode.sv
  - alu_basic.sv
  - alu_mul.sv
  - alu_div.sv
  - alu_exec.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_alu_checker.sv
      - tb_alu_top.sv

// File: alu_basic.sv
`timescale 1ns/1ns
module alu_basic (
  input  alu_pkg::alu_op_e alu_op_i,
  input  logic             word_i,
  input  alu_pkg::xlen_t   src1_i,
  input  alu_pkg::xlen_t   src2_i,
  output alu_pkg::xlen_t   result_o
);
  import alu_pkg::*;

  xlen_t  sum;
  xlen_t  diff;
  xlen_t  shift_src;
  xlen_t  raw;
  shamt_t shamt;
  logic   lt_s;
  logic   lt_u;

  assign sum  = src1_i + src2_i;
  assign diff = src1_i - src2_i;
  assign lt_s = $signed(src1_i) < $signed(src2_i);
  assign lt_u = src1_i < src2_i;

  // word shifts only see 5 bits of amount
  assign shamt = word_i ? {1'b0, src2_i[4:0]} : src2_i[5:0];

  // word form shifts the low half, extended to suit the shift type
  always_comb begin
    if (!word_i) begin
      shift_src = src1_i;
    end else if (alu_op_i == SRA) begin
      shift_src = sext_word(src1_i[WLEN-1:0]);
    end else begin
      shift_src = {{(XLEN-WLEN){1'b0}}, src1_i[WLEN-1:0]};
    end
  end

  always_comb begin
    case (alu_op_i)
      ADD:      raw = sum;
      SUB:      raw = diff;
      SLL:      raw = shift_src << shamt;
      SRL:      raw = shift_src >> shamt;
      SRA:      raw = $signed(shift_src) >>> shamt;
      AND:      raw = src1_i & src2_i;
      OR:       raw = src1_i | src2_i;
      XOR:      raw = src1_i ^ src2_i;
      SLT:      raw = xlen_t'(lt_s);
      SLTU:     raw = xlen_t'(lt_u);
      EQ:       raw = xlen_t'(src1_i == src2_i);
      NE:       raw = xlen_t'(src1_i != src2_i);
      GE:       raw = xlen_t'(!lt_s);
      GEU:      raw = xlen_t'(!lt_u);
      PASS_B:   raw = src2_i;  // lui
      ADD_CLR0: raw = {sum[XLEN-1:1], 1'b0};
      ZERO:     raw = '0;
      default:  raw = '0;
    endcase
  end

  assign result_o = word_i ? sext_word(raw[WLEN-1:0]) : raw;

endmodule

// File: alu_decode.sv
`timescale 1ns/1ns
module alu_decode (
  input  alu_pkg::alu_req_t  req_i,
  output alu_pkg::alu_op_e   alu_op_o,
  output logic               word_o,
  output alu_pkg::mdu_ctrl_t mdu_ctrl_o
);
  import rv_isa_pkg::*;
  import alu_pkg::*;

  logic alt;
  logic reg_form;
  logic muldiv;

  assign alt      = req_i.funct7[F7_ALT_BIT];
  assign reg_form = (req_i.opcode == OPC_OP) || (req_i.opcode == OPC_OP_32);
  assign muldiv   = reg_form && (req_i.funct7 == F7_MULDIV);
  assign word_o   = (req_i.opcode == OPC_OP_32) || (req_i.opcode == OPC_OP_IMM_32);

  always_comb begin
    alu_op_o = ZERO;
    case (req_i.opcode)
      OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
        case (req_i.funct3)
          F3_ADD_SUB: alu_op_o = (reg_form && alt) ? SUB : ADD;  // addi has no sub
          F3_SLL:     alu_op_o = SLL;
          F3_SLT:     alu_op_o = SLT;
          F3_SLTU:    alu_op_o = SLTU;
          F3_XOR:     alu_op_o = XOR;
          F3_SR:      alu_op_o = alt ? SRA : SRL;
          F3_OR:      alu_op_o = OR;
          F3_AND:     alu_op_o = AND;
          default:    alu_op_o = ZERO;
        endcase
      end
      OPC_BRANCH: begin
        case (req_i.funct3)
          F3_BEQ:  alu_op_o = EQ;
          F3_BNE:  alu_op_o = NE;
          F3_BLT:  alu_op_o = SLT;
          F3_BGE:  alu_op_o = GE;
          F3_BLTU: alu_op_o = SLTU;
          F3_BGEU: alu_op_o = GEU;
          default: alu_op_o = ZERO;
        endcase
      end
      OPC_LUI:    alu_op_o = PASS_B;
      OPC_JALR:   alu_op_o = ADD_CLR0;
      OPC_AUIPC, OPC_LOAD, OPC_STORE, OPC_JAL: alu_op_o = ADD;
      OPC_SYSTEM: alu_op_o = ZERO;
      default:    alu_op_o = ZERO;
    endcase
  end

  always_comb begin
    mdu_ctrl_o        = '0;
    mdu_ctrl_o.is_mul = muldiv && !req_i.funct3[2];
    mdu_ctrl_o.is_div = muldiv && req_i.funct3[2];
    case (req_i.funct3)
      F3_MULH: begin
        mdu_ctrl_o.src1_signed = 1'b1;
        mdu_ctrl_o.src2_signed = 1'b1;
        mdu_ctrl_o.sel_high    = 1'b1;
      end
      F3_MULHSU: begin
        mdu_ctrl_o.src1_signed = 1'b1;
        mdu_ctrl_o.sel_high    = 1'b1;
      end
      F3_MULHU: mdu_ctrl_o.sel_high = 1'b1;
      F3_DIV: begin
        mdu_ctrl_o.src1_signed = 1'b1;
        mdu_ctrl_o.src2_signed = 1'b1;
      end
      F3_REM: begin
        mdu_ctrl_o.src1_signed = 1'b1;
        mdu_ctrl_o.src2_signed = 1'b1;
        mdu_ctrl_o.sel_high    = 1'b1;
      end
      F3_REMU:         mdu_ctrl_o.sel_high = 1'b1;
      F3_MUL, F3_DIVU: mdu_ctrl_o.sel_high = 1'b0;  // low product, quotient
      default:         mdu_ctrl_o.sel_high = 1'b0;
    endcase
  end

endmodule

// File: alu_div.sv
`timescale 1ns/1ns
module alu_div (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               start_i,
  input  logic               word_i,
  input  alu_pkg::mdu_ctrl_t ctrl_i,
  input  alu_pkg::xlen_t     src1_i,
  input  alu_pkg::xlen_t     src2_i,
  output logic               busy_o,
  output logic               done_o,
  output alu_pkg::xlen_t     result_o
);
  import alu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

  state_e        state_q;
  shamt_t        cnt_q;
  xlen_t         quo_q;   // dividend in, quotient out
  xlen_t         rem_q;
  xlen_t         dsor_q;
  xlen_t         result_q;
  logic          quo_neg_q, rem_neg_q, word_q, high_q, dz_q;
  logic          last;
  xlen_t         op1, op2, mag1, mag2;
  logic          neg1, neg2, dz;
  logic [XLEN:0] shifted;
  logic [XLEN:0] trial;
  logic          ge;
  xlen_t         rem_nx, quo_nx;
  xlen_t         quo_fix, rem_fix, sel;

  assign op1  = word_i ? sext_word(src1_i[WLEN-1:0]) : src1_i;
  assign op2  = word_i ? sext_word(src2_i[WLEN-1:0]) : src2_i;
  assign neg1 = ctrl_i.src1_signed & op1[XLEN-1];
  assign neg2 = ctrl_i.src2_signed & op2[XLEN-1];
  assign mag1 = neg1 ? -op1 : op1;
  assign mag2 = neg2 ? -op2 : op2;
  assign dz   = word_i ? (src2_i[WLEN-1:0] == '0) : (src2_i == '0);

  // restoring step, one quotient bit
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign ge      = shifted >= {1'b0, dsor_q};
  assign trial   = shifted - {1'b0, dsor_q};
  assign rem_nx  = ge ? trial[XLEN-1:0] : shifted[XLEN-1:0];
  assign quo_nx  = {quo_q[XLEN-2:0], ge};
  assign last    = dz_q || (cnt_q == '0);

  always_comb begin
    if (dz_q) begin
      quo_fix = '1;
      rem_fix = rem_q;  // holds the raw dividend
    end else begin
      quo_fix = quo_neg_q ? -quo_nx : quo_nx;
      rem_fix = rem_neg_q ? -rem_nx : rem_nx;
    end
    sel = high_q ? rem_fix : quo_fix;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (start_i) state_q <= S_RUN;
        S_RUN:   if (last) state_q <= S_DONE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      quo_neg_q <= neg1 ^ neg2;
      rem_neg_q <= neg1;       // remainder follows dividend
      word_q    <= word_i;
      high_q    <= ctrl_i.sel_high;
      dz_q      <= dz;
      cnt_q     <= word_i ? shamt_t'(WLEN-1) : shamt_t'(XLEN-1);
      rem_q     <= dz ? op1 : '0;
      quo_q     <= word_i ? {mag1[WLEN-1:0], {(XLEN-WLEN){1'b0}}} : mag1;
      dsor_q    <= word_i ? {{(XLEN-WLEN){1'b0}}, mag2[WLEN-1:0]} : mag2;
    end else if (state_q == S_RUN) begin
      rem_q <= rem_nx;
      quo_q <= quo_nx;
      cnt_q <= cnt_q - 1'b1;
      if (last) begin
        result_q <= word_q ? sext_word(sel[WLEN-1:0]) : sel;
      end
    end
  end

  assign busy_o   = (state_q == S_RUN);
  assign done_o   = (state_q == S_DONE);
  assign result_o = result_q;

  a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i) start_i |-> !busy_o);
  a_done_pulse:    assert property (@(posedge clk) disable iff (reset_i) done_o |=> !done_o);

endmodule

// File: alu_exec.sv
`timescale 1ns/1ns
module alu_exec (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              valid_i,
  input  alu_pkg::alu_req_t req_i,
  output logic              ready_o,
  output alu_pkg::xlen_t    result_o
);
  import alu_pkg::*;

  alu_op_e   alu_op;
  logic      word;
  mdu_ctrl_t mdu_ctrl;
  xlen_t     basic_res, mul_res, div_res;
  logic      mul_start, mul_busy, mul_done;
  logic      div_start, div_busy, div_done;

  alu_decode alu_decode_inst (
    .req_i      (req_i),
    .alu_op_o   (alu_op),
    .word_o     (word),
    .mdu_ctrl_o (mdu_ctrl)
  );

  alu_basic alu_basic_inst (
    .alu_op_i (alu_op),
    .word_i   (word),
    .src1_i   (req_i.src1),
    .src2_i   (req_i.src2),
    .result_o (basic_res)
  );

  // no restart while the unit is running or just finished
  assign mul_start = valid_i && mdu_ctrl.is_mul && !mul_busy && !mul_done;
  assign div_start = valid_i && mdu_ctrl.is_div && !div_busy && !div_done;

  alu_mul alu_mul_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (mul_start),
    .word_i   (word),
    .ctrl_i   (mdu_ctrl),
    .src1_i   (req_i.src1),
    .src2_i   (req_i.src2),
    .busy_o   (mul_busy),
    .done_o   (mul_done),
    .result_o (mul_res)
  );

  alu_div alu_div_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (div_start),
    .word_i   (word),
    .ctrl_i   (mdu_ctrl),
    .src1_i   (req_i.src1),
    .src2_i   (req_i.src2),
    .busy_o   (div_busy),
    .done_o   (div_done),
    .result_o (div_res)
  );

  always_comb begin
    if (mdu_ctrl.is_mul) begin
      ready_o  = valid_i && mul_done;
      result_o = mul_res;
    end else if (mdu_ctrl.is_div) begin
      ready_o  = valid_i && div_done;
      result_o = div_res;
    end else begin
      ready_o  = valid_i;  // single cycle path
      result_o = basic_res;
    end
  end

  a_ready_valid: assert property (@(posedge clk) disable iff (reset_i) $rose(ready_o) |-> valid_i);
  // upstream must still hold the request when a unit finishes
  a_mul_held: assert property (@(posedge clk) disable iff (reset_i)
                               mul_done |-> valid_i && mdu_ctrl.is_mul);
  a_div_held: assert property (@(posedge clk) disable iff (reset_i)
                               div_done |-> valid_i && mdu_ctrl.is_div);

endmodule

// File: alu_mul.sv
`timescale 1ns/1ns
module alu_mul (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               start_i,
  input  logic               word_i,
  input  alu_pkg::mdu_ctrl_t ctrl_i,
  input  alu_pkg::xlen_t     src1_i,
  input  alu_pkg::xlen_t     src2_i,
  output logic               busy_o,
  output logic               done_o,
  output alu_pkg::xlen_t     result_o
);
  import alu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

  state_e            state_q;
  shamt_t            cnt_q;
  logic [2*XLEN-1:0] acc_q;
  logic [2*XLEN-1:0] acc_nx;
  logic [2*XLEN-1:0] prod_abs;
  logic [2*XLEN-1:0] prod;
  logic [XLEN:0]     part;  // upper half with carry
  xlen_t             mcand_q;
  xlen_t             result_q;
  xlen_t             op1, op2, mag1, mag2;
  logic              neg1, neg2;
  logic              neg_q, word_q, high_q;

  assign op1  = word_i ? sext_word(src1_i[WLEN-1:0]) : src1_i;
  assign op2  = word_i ? sext_word(src2_i[WLEN-1:0]) : src2_i;
  assign neg1 = ctrl_i.src1_signed & op1[XLEN-1];
  assign neg2 = ctrl_i.src2_signed & op2[XLEN-1];
  assign mag1 = neg1 ? -op1 : op1;
  assign mag2 = neg2 ? -op2 : op2;

  // one multiplier bit per step, shift right
  assign part     = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);
  assign acc_nx   = {part, acc_q[XLEN-1:1]};
  assign prod_abs = word_q ? (acc_nx >> WLEN) : acc_nx;  // 32 steps leave it offset
  assign prod     = neg_q ? -prod_abs : prod_abs;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (start_i) state_q <= S_RUN;
        S_RUN:   if (cnt_q == '0) state_q <= S_DONE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      neg_q   <= neg1 ^ neg2;
      word_q  <= word_i;
      high_q  <= ctrl_i.sel_high;
      cnt_q   <= word_i ? shamt_t'(WLEN-1) : shamt_t'(XLEN-1);
      mcand_q <= word_i ? {{(XLEN-WLEN){1'b0}}, mag1[WLEN-1:0]} : mag1;
      acc_q   <= {{XLEN{1'b0}}, (word_i ? {{(XLEN-WLEN){1'b0}}, mag2[WLEN-1:0]} : mag2)};
    end else if (state_q == S_RUN) begin
      acc_q <= acc_nx;
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == '0) begin
        if (word_q) begin
          result_q <= sext_word(prod[WLEN-1:0]);  // mulw
        end else begin
          result_q <= high_q ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end
      end
    end
  end

  assign busy_o   = (state_q == S_RUN);
  assign done_o   = (state_q == S_DONE);
  assign result_o = result_q;

  a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i) start_i |-> !busy_o);
  a_done_pulse:    assert property (@(posedge clk) disable iff (reset_i) done_o |=> !done_o);

endmodule

// File: alu_pkg.sv
package alu_pkg;

  localparam int unsigned XLEN = 64;
  localparam int unsigned WLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [5:0]      shamt_t;

  typedef enum logic [4:0] {
    ADD,
    SUB,
    SLL,
    SRL,
    SRA,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    EQ,
    NE,
    GE,
    GEU,
    PASS_B,
    ADD_CLR0,  // jalr target
    ZERO
  } alu_op_e;

  typedef struct packed {
    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::funct7_t funct7;
    xlen_t               src1;
    xlen_t               src2;
  } alu_req_t;

  typedef struct packed {
    logic is_mul;
    logic is_div;
    logic src1_signed;
    logic src2_signed;
    logic sel_high;  // high product or remainder
  } mdu_ctrl_t;

  function automatic xlen_t sext_word(input logic [WLEN-1:0] w);
    return {{(XLEN-WLEN){w[WLEN-1]}}, w};
  endfunction

endpackage

// File: compile.f
rv_isa_pkg.sv
alu_pkg.sv
alu_decode.sv
alu_basic.sv
alu_mul.sv
alu_div.sv
alu_exec.sv
tb_clock_gen.sv
tb_alu_checker.sv
tb_alu_top.sv

// File: rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  localparam opcode_t OPC_LOAD      = 7'b0000011;
  localparam opcode_t OPC_OP_IMM    = 7'b0010011;
  localparam opcode_t OPC_AUIPC     = 7'b0010111;
  localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
  localparam opcode_t OPC_STORE     = 7'b0100011;
  localparam opcode_t OPC_OP        = 7'b0110011;
  localparam opcode_t OPC_LUI       = 7'b0110111;
  localparam opcode_t OPC_OP_32     = 7'b0111011;
  localparam opcode_t OPC_BRANCH    = 7'b1100011;
  localparam opcode_t OPC_JALR      = 7'b1100111;
  localparam opcode_t OPC_JAL       = 7'b1101111;
  localparam opcode_t OPC_SYSTEM    = 7'b1110011;

  localparam funct7_t     F7_MULDIV  = 7'b0000001;
  localparam int unsigned F7_ALT_BIT = 5;  // sub / sra select

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SR      = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct3_t F3_MUL    = 3'b000;
  localparam funct3_t F3_MULH   = 3'b001;
  localparam funct3_t F3_MULHSU = 3'b010;
  localparam funct3_t F3_MULHU  = 3'b011;
  localparam funct3_t F3_DIV    = 3'b100;
  localparam funct3_t F3_DIVU   = 3'b101;
  localparam funct3_t F3_REM    = 3'b110;
  localparam funct3_t F3_REMU   = 3'b111;

endpackage

// File: tb_alu_checker.sv
`timescale 1ns/1ns
module tb_alu_checker (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              valid_i,
  input  alu_pkg::alu_req_t req_i,
  input  logic              ready_i,
  input  alu_pkg::xlen_t    result_i,
  output int                err_cnt_o
);
  import rv_isa_pkg::*;
  import alu_pkg::*;

  int    errors = 0;
  xlen_t expected;

  assign err_cnt_o = errors;

  function automatic xlen_t sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic needs_mdu(input alu_req_t r);
    return ((r.opcode == OPC_OP) || (r.opcode == OPC_OP_32)) && (r.funct7 == F7_MULDIV);
  endfunction

  function automatic xlen_t alu_model(input alu_req_t r);
    logic         word;
    logic         reg_op;
    logic         alt;
    logic         s1s;
    logic         s2s;
    logic [127:0] prod;
    xlen_t        a;
    xlen_t        b;
    xlen_t        raw;
    word   = (r.opcode == OPC_OP_32) || (r.opcode == OPC_OP_IMM_32);
    reg_op = (r.opcode == OPC_OP) || (r.opcode == OPC_OP_32);
    alt    = r.funct7[F7_ALT_BIT];
    raw    = '0;
    if (needs_mdu(r)) begin
      s1s = r.funct3[2] ? !r.funct3[0] : (r.funct3 == F3_MULH || r.funct3 == F3_MULHSU);
      s2s = r.funct3[2] ? !r.funct3[0] : (r.funct3 == F3_MULH);
      a = word ? (s1s ? sext32(r.src1[31:0]) : {32'b0, r.src1[31:0]}) : r.src1;
      b = word ? (s2s ? sext32(r.src2[31:0]) : {32'b0, r.src2[31:0]}) : r.src2;
      if (!r.funct3[2]) begin
        // full 128-bit product of the extended operands
        prod = (s1s ? {{64{a[63]}}, a} : {64'b0, a}) * (s2s ? {{64{b[63]}}, b} : {64'b0, b});
        raw  = (r.funct3 == F3_MUL) ? prod[63:0] : prod[127:64];
      end else if (b == '0) begin
        raw = r.funct3[1] ? a : '1;  // rem keeps dividend
      end else if (s1s && a == {1'b1, 63'b0} && b == '1) begin
        raw = r.funct3[1] ? '0 : a;  // signed overflow
      end else if (s1s) begin
        raw = r.funct3[1] ? xlen_t'($signed(a) % $signed(b)) : xlen_t'($signed(a) / $signed(b));
      end else begin
        raw = r.funct3[1] ? a % b : a / b;
      end
      return word ? sext32(raw[31:0]) : raw;
    end
    case (r.opcode)
      OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
        case (r.funct3)
          F3_ADD_SUB: raw = (reg_op && alt) ? r.src1 - r.src2 : r.src1 + r.src2;
          F3_SLL:     raw = word ? {32'b0, r.src1[31:0]} << r.src2[4:0] : r.src1 << r.src2[5:0];
          F3_SLT:     raw = {63'b0, $signed(r.src1) < $signed(r.src2)};
          F3_SLTU:    raw = {63'b0, r.src1 < r.src2};
          F3_XOR:     raw = r.src1 ^ r.src2;
          F3_OR:      raw = r.src1 | r.src2;
          F3_AND:     raw = r.src1 & r.src2;
          default: begin
            if (word && alt) raw = $signed(r.src1[31:0]) >>> r.src2[4:0];
            else if (word) raw = {32'b0, r.src1[31:0]} >> r.src2[4:0];
            else if (alt) raw = $signed(r.src1) >>> r.src2[5:0];
            else raw = r.src1 >> r.src2[5:0];
          end
        endcase
      end
      OPC_BRANCH: begin
        case (r.funct3)
          F3_BEQ:  raw = {63'b0, r.src1 == r.src2};
          F3_BNE:  raw = {63'b0, r.src1 != r.src2};
          F3_BLT:  raw = {63'b0, $signed(r.src1) < $signed(r.src2)};
          F3_BGE:  raw = {63'b0, $signed(r.src1) >= $signed(r.src2)};
          F3_BLTU: raw = {63'b0, r.src1 < r.src2};
          F3_BGEU: raw = {63'b0, r.src1 >= r.src2};
          default: raw = '0;
        endcase
      end
      OPC_LUI:  raw = r.src2;
      OPC_JALR: raw = (r.src1 + r.src2) & ~64'd1;
      OPC_AUIPC, OPC_LOAD, OPC_STORE, OPC_JAL: raw = r.src1 + r.src2;
      default:  raw = '0;  // system
    endcase
    return word ? sext32(raw[31:0]) : raw;
  endfunction

  // sample mid-cycle, inputs change just after the rising edge
  always @(negedge clk_i) begin
    if (ready_i && !valid_i) begin
      $display("ERROR at %0t: ready_o high while valid_i is low", $time);
      errors++;
    end
    if (valid_i && !reset_i) begin
      expected = alu_model(req_i);
      if (!ready_i && !needs_mdu(req_i)) begin
        $display("ERROR at %0t: basic request opcode=%h without ready_o", $time, req_i.opcode);
        errors++;
      end
      if (ready_i && result_i !== expected) begin
        $display("ERROR at %0t: opcode=%h f3=%h f7=%h src1=%h src2=%h expected %h got %h",
                 $time, req_i.opcode, req_i.funct3, req_i.funct7, req_i.src1, req_i.src2,
                 expected, result_i);
        errors++;
      end
    end
  end

endmodule

// File: tb_alu_top.sv
`timescale 1ns/1ns
module tb_alu_top;
  import rv_isa_pkg::*;
  import alu_pkg::*;

  localparam int NUM_REQS = 600;
  localparam int MAX_WAIT = 200;
  localparam opcode_t OPCODES [14] = '{OPC_OP, OPC_OP, OPC_OP_32, OPC_OP_32, OPC_OP_IMM,
    OPC_OP_IMM_32, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE,
    OPC_SYSTEM};
  localparam xlen_t CORNERS [8] = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000,
    64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000, 64'hffff_ffff_8000_0000,
    64'h0000_0000_ffff_ffff};
  localparam xlen_t MIN64 = 64'h8000_0000_0000_0000;

  logic        clk;
  logic        reset;
  logic        valid;
  alu_req_t    req;
  logic        ready;
  xlen_t       result;
  int          err_cnt;
  int          timeouts = 0;
  int          waited;
  logic [31:0] seed = 32'h12b0_8bfd;
  alu_req_t    rnd_req;

  tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .reset_o(reset));

  alu_exec alu_exec_inst (
    .clk      (clk),
    .reset_i  (reset),
    .valid_i  (valid),
    .req_i    (req),
    .ready_o  (ready),
    .result_o (result)
  );

  tb_alu_checker tb_alu_checker_inst (
    .clk_i     (clk),
    .reset_i   (reset),
    .valid_i   (valid),
    .req_i     (req),
    .ready_i   (ready),
    .result_i  (result),
    .err_cnt_o (err_cnt)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return (next_rand() >> 8) % n;  // low lcg bits are weak
  endfunction

  function automatic xlen_t pick_operand();
    if (pick(4) == 0) return CORNERS[pick(8)];
    return {next_rand(), next_rand()};
  endfunction

  function automatic alu_req_t make_req(input opcode_t opc, input funct3_t f3,
                                        input funct7_t f7, input xlen_t a, input xlen_t b);
    return '{opcode: opc, funct3: f3, funct7: f7, src1: a, src2: b};
  endfunction

  task automatic random_req(output alu_req_t r);
    r.opcode = OPCODES[pick(14)];
    r.funct3 = funct3_t'(pick(8));
    case (pick(4))
      0: r.funct7 = 7'h00;
      1: r.funct7 = 7'h20;
      default: r.funct7 = F7_MULDIV;
    endcase
    if (r.opcode == OPC_BRANCH && r.funct3[2:1] == 2'b01) r.funct3 = F3_BEQ;
    if (r.opcode == OPC_OP_32 && r.funct7 == F7_MULDIV && !r.funct3[2]) r.funct3 = F3_MUL;
    r.src1 = pick_operand();
    r.src2 = pick_operand();
  endtask

  // starts 1 ns after a rising edge and returns at the same offset
  task automatic run_req(input alu_req_t r);
    int cycles;
    valid  = 1'b1;
    req    = r;
    cycles = 0;
    @(negedge clk);
    while (!ready && cycles < MAX_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      $display("Timeout: no ready_o within %0d cycles for opcode %h at %0t",
               MAX_WAIT, r.opcode, $time);
      timeouts++;
    end
    @(posedge clk);
    #1;
    valid = 1'b0;
  endtask

  initial begin
    valid  = 1'b0;
    req    = '0;
    waited = 0;
    while (reset !== 1'b0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("Timeout: reset never released");
      timeouts++;
    end
    @(posedge clk);
    #1;
    run_req(make_req(OPC_OP, F3_DIV, F7_MULDIV, MIN64, '1));
    run_req(make_req(OPC_OP, F3_REM, F7_MULDIV, MIN64, '1));
    run_req(make_req(OPC_OP_32, F3_DIV, F7_MULDIV, 64'hffff_ffff_8000_0000, '1));
    run_req(make_req(OPC_OP_32, F3_REM, F7_MULDIV, 64'hffff_ffff_8000_0000, '1));
    run_req(make_req(OPC_OP, F3_DIVU, F7_MULDIV, 64'h1234, '0));
    run_req(make_req(OPC_OP, F3_REM, F7_MULDIV, 64'hffff_ffff_ffff_fffb, '0));
    run_req(make_req(OPC_OP_32, F3_DIV, F7_MULDIV, 64'h7, 64'hffff_ffff_0000_0000));
    run_req(make_req(OPC_OP_32, F3_REMU, F7_MULDIV, 64'h8000_0007, 64'h1_0000_0000));
    run_req(make_req(OPC_OP, F3_MULH, F7_MULDIV, MIN64, MIN64));
    run_req(make_req(OPC_OP, F3_MULHSU, F7_MULDIV, '1, '1));
    for (int i = 0; i < NUM_REQS; i++) begin
      random_req(rnd_req);
      run_req(rnd_req);
      if (pick(8) == 0) begin
        @(posedge clk);  // idle cycle with valid low
        #1;
      end
    end
    $display("requests=%0d errors=%0d timeouts=%0d", NUM_REQS + 10, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule
